/* program.hex */
// Each line is one RV32I instruction as two halfwords, low half first
// Lines start at byte address 0x00 and step by 4
0513 0000 // 0x00 addi x10, x0, 0
0593 0010 // 0x04 addi x11, x0, 1
0613 0060 // 0x08 addi x12, x0, 6
0693 F000 // 0x0C addi x13, x0, -256   LED register at 0xFF00
0533 00B5 // 0x10 add  x10, x10, x11
A023 00A6 // 0x14 sw   x10, 0(x13)
8593 0015 // 0x18 addi x11, x11, 1
9AE3 FEC5 // 0x1C bne  x11, x12, -12
2023 10A0 // 0x20 sw   x10, 0x100(x0)
2703 1000 // 0x24 lw   x14, 0x100(x0)
0713 0017 // 0x28 addi x14, x14, 1
A023 00E6 // 0x2C sw   x14, 0(x13)
006F 0000 // 0x30 jal  x0, 0

/* sources.f */
verilog/soc_pkg.sv
verilog/riscv_regfile.sv
verilog/riscv.sv
verilog/mem.sv
verilog/shield_v1.sv
verilog/de10nano.sv
bench/tb_de10nano.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root,
# so that mem finds program.hex

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_de10nano \
    -Mdir obj_dir -o tb_de10nano -f sources.f > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_de10nano > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

/* bench/tb_de10nano.sv */
module tb_de10nano;

  import soc_pkg::*;

  localparam int SPI_DIV = 4;
  localparam int RESET_CYCLES = 3;
  localparam int SYNC_STAGES = 2;
  localparam int IDLE_CYCLES = 200;
  // Two half-periods of SPI_DIV clocks per bit
  localparam int SPI_CYCLES = DISP_INIT_LEN * 8 * 2 * SPI_DIV;
  // About 30 executed instructions of at most 10 cycles each
  localparam int PROG_CYCLES = 300;
  localparam int TIMEOUT_CYCLES = 20 * (SPI_CYCLES + IDLE_CYCLES + PROG_CYCLES);

  logic        FPGA_CLK1_50;
  logic        FPGA_CLK2_50;
  logic        FPGA_CLK3_50;
  logic [7:0]  LED;
  logic [1:0]  KEY;
  logic [3:0]  SW;
  logic        ADC_CONVST;
  logic        ADC_SCK;
  logic        ADC_SDI;
  logic        ADC_SDO;
  logic [15:0] ARDUINO_IO;
  logic        ARDUINO_RESET_N;

  int error_count;
  int tests_passed;
  int tests_failed;
  int cycle_count;

  // SPI monitor state
  logic       sck_prev;
  int         bit_count;
  logic [7:0] rx_shift;
  logic       byte_dc;
  logic       dc_unstable;
  logic       frame_error;
  logic [8:0] captured [$];

  de10nano #(
    .SPI_DIV (SPI_DIV)
  ) dut0 (
    .FPGA_CLK1_50    (FPGA_CLK1_50),
    .FPGA_CLK2_50    (FPGA_CLK2_50),
    .FPGA_CLK3_50    (FPGA_CLK3_50),
    .LED             (LED),
    .KEY             (KEY),
    .SW              (SW),
    .ADC_CONVST      (ADC_CONVST),
    .ADC_SCK         (ADC_SCK),
    .ADC_SDI         (ADC_SDI),
    .ADC_SDO         (ADC_SDO),
    .ARDUINO_IO      (ARDUINO_IO),
    .ARDUINO_RESET_N (ARDUINO_RESET_N)
  );

  initial begin
    FPGA_CLK1_50 = 1'b0;
    forever #5 FPGA_CLK1_50 = ~FPGA_CLK1_50;
  end

  // Rising sck seen in the clock domain, so mosi and dc are already stable
  always @(posedge FPGA_CLK1_50) begin
    if (LED[0] !== 1'b0) begin
      sck_prev    <= 1'b0;
      bit_count   <= 0;
      dc_unstable <= 1'b0;
      frame_error <= 1'b0;
      captured.delete();
    end else begin
      sck_prev <= ARDUINO_IO[13];
      if (ARDUINO_IO[10] === 1'b1 && bit_count != 0) frame_error <= 1'b1;
      if (ARDUINO_IO[10] === 1'b0 && ARDUINO_IO[13] === 1'b1 && sck_prev === 1'b0) begin
        if (bit_count == 0) begin
          byte_dc <= ARDUINO_IO[8];
        end else if (ARDUINO_IO[8] !== byte_dc) begin
          dc_unstable <= 1'b1;
        end
        if (bit_count == 7) begin
          captured.push_back({ARDUINO_IO[8], rx_shift[6:0], ARDUINO_IO[11]});
          bit_count <= 0;
        end else begin
          bit_count <= bit_count + 1;
        end
        rx_shift <= {rx_shift[6:0], ARDUINO_IO[11]};
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error %s: expected %h, got %h", name, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    error_count++;
  endtask

  task automatic close_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("%s: passed", name);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d errors", name, error_count - errors_before);
      tests_failed++;
    end
  endtask

  task automatic wait_led_change(output logic [1:0] value);
    logic [1:0] start_value;
    start_value = LED[3:2];
    while (LED[3:2] === start_value) @(negedge FPGA_CLK1_50);
    value = LED[3:2];
  endtask

  // Parked board pins and the LED copy of the SPI lines
  task automatic check_board_pins();
    logic [15:0] unused_io;
    logic [3:0]  spi_pins;
    unused_io = ARDUINO_IO & ~16'h2D00;
    spi_pins = {ARDUINO_IO[11], ARDUINO_IO[8], ARDUINO_IO[10], ARDUINO_IO[13]};
    if (unused_io !== 16'h0000) begin
      report_mismatch("ARDUINO_IO unused bits", 32'd0, 32'(unused_io));
    end
    if (ARDUINO_RESET_N !== 1'b1) begin
      report_mismatch("ARDUINO_RESET_N", 32'd1, 32'(ARDUINO_RESET_N));
    end
    if (ADC_CONVST !== 1'b0) report_mismatch("ADC_CONVST", 32'd0, 32'(ADC_CONVST));
    if (ADC_SCK !== 1'b0) report_mismatch("ADC_SCK", 32'd0, 32'(ADC_SCK));
    if (ADC_SDI !== 1'b0) report_mismatch("ADC_SDI", 32'd0, 32'(ADC_SDI));
    if (LED[7:4] !== spi_pins) report_mismatch("LED[7:4]", 32'(spi_pins), 32'(LED[7:4]));
  endtask

  task automatic reset_behaviour();
    int errors_before;
    errors_before = error_count;
    repeat (RESET_CYCLES + SYNC_STAGES) @(posedge FPGA_CLK1_50);
    @(negedge FPGA_CLK1_50);
    if (LED[0] !== 1'b1) report_mismatch("LED[0]", 32'd1, 32'(LED[0]));
    if (LED[3:2] !== 2'b00) report_mismatch("LED[3:2]", 32'd0, 32'(LED[3:2]));
    @(posedge FPGA_CLK1_50);
    KEY[0] <= 1'b1;
    while (LED[0] !== 1'b0) @(negedge FPGA_CLK1_50);
    // Shield has not opened its first frame yet
    if (ARDUINO_IO[10] !== 1'b1) report_mismatch("ARDUINO_IO[10]", 32'd1, 32'(ARDUINO_IO[10]));
    if (LED[1] !== 1'b0) report_mismatch("LED[1]", 32'd0, 32'(LED[1]));
    check_board_pins();
    close_test("reset_behaviour", errors_before);
  endtask

  task automatic idle_until_start();
    int   errors_before;
    logic reported;
    errors_before = error_count;
    reported = 1'b0;
    repeat (IDLE_CYCLES) begin
      @(negedge FPGA_CLK1_50);
      if (LED[3:2] !== 2'b00 && !reported) begin
        report_mismatch("LED[3:2]", 32'd0, 32'(LED[3:2]));
        reported = 1'b1;
      end
    end
    close_test("idle_until_start", errors_before);
  endtask

  task automatic display_init_sequence();
    int         errors_before;
    int         pins_before;
    int         i;
    logic       pins_reported;
    logic [8:0] expected_byte;
    errors_before = error_count;
    pins_reported = 1'b0;
    // Board pins follow the SPI lines while bytes are going out
    while (LED[1] !== 1'b1) begin
      @(negedge FPGA_CLK1_50);
      if (!pins_reported) begin
        pins_before = error_count;
        check_board_pins();
        pins_reported = (error_count != pins_before);
      end
    end
    if (captured.size() != DISP_INIT_LEN) begin
      report_problem($sformatf("monitor captured %0d display bytes instead of %0d",
                               captured.size(), DISP_INIT_LEN));
    end
    for (i = 0; i < captured.size() && i < DISP_INIT_LEN; i++) begin
      expected_byte = DISP_INIT[i];
      if (captured[i] !== expected_byte) begin
        report_mismatch($sformatf("display byte %0d {dc,data}", i),
                        32'(expected_byte), 32'(captured[i]));
      end
    end
    if (dc_unstable) report_problem("data/command flag changed in the middle of a byte");
    if (frame_error) report_problem("chip select went high before a byte was complete");
    // Sequence should stay finished
    repeat (50) @(negedge FPGA_CLK1_50);
    if (LED[1] !== 1'b1) report_mismatch("LED[1]", 32'd1, 32'(LED[1]));
    if (ARDUINO_IO[10] !== 1'b1) report_mismatch("ARDUINO_IO[10]", 32'd1, 32'(ARDUINO_IO[10]));
    if (captured.size() != DISP_INIT_LEN) report_problem("display bytes were sent after the end");
    check_board_pins();
    close_test("display_init_sequence", errors_before);
  endtask

  task automatic partial_sums_on_leds();
    int         errors_before;
    int         sum;
    int         i;
    int         k;
    logic [1:0] last;
    logic [1:0] seen;
    logic [1:0] expected [$];
    errors_before = error_count;
    sum = 0;
    last = 2'b00;
    // Repeated low bits do not show as a change
    for (i = 1; i <= 5; i++) begin
      sum += i;
      if (sum[1:0] != last) begin
        expected.push_back(sum[1:0]);
        last = sum[1:0];
      end
    end
    @(posedge FPGA_CLK1_50);
    KEY[1] <= 1'b0;
    @(posedge FPGA_CLK1_50);
    KEY[1] <= 1'b1;
    for (k = 0; k < expected.size(); k++) begin
      wait_led_change(seen);
      if (seen !== expected[k]) begin
        report_mismatch($sformatf("LED[3:2] change %0d", k), 32'(expected[k]), 32'(seen));
      end
    end
    close_test("partial_sums_on_leds", errors_before);
  endtask

  task automatic load_store_round_trip();
    int         errors_before;
    int         sum;
    int         i;
    int         final_value;
    logic [1:0] seen;
    errors_before = error_count;
    sum = 0;
    for (i = 1; i <= 5; i++) sum += i;
    final_value = (sum + 1) % 4;
    wait_led_change(seen);
    if (seen !== final_value[1:0]) report_mismatch("LED[3:2]", 32'(final_value), 32'(seen));
    // Core sits on its JAL 0 from here on
    repeat (100) begin
      @(negedge FPGA_CLK1_50);
      if (LED[3:2] !== seen) begin
        report_problem("LEDs changed after the program should have halted");
        seen = LED[3:2];
      end
    end
    close_test("load_store_round_trip", errors_before);
  endtask

  initial begin
    KEY = 2'b10;
    SW = 4'h0;
    FPGA_CLK2_50 = 1'b0;
    FPGA_CLK3_50 = 1'b0;
    ADC_SDO = 1'b0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    reset_behaviour();
    idle_until_start();
    display_init_sequence();
    partial_sums_on_leds();
    load_store_round_trip();
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge FPGA_CLK1_50);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* verilog/de10nano.sv */
module de10nano #(
  parameter logic [15:0] MEM_LO  = 16'h0000,
  parameter logic [15:0] MEM_HI  = 16'h0FFF,
  parameter int          SPI_DIV = 4
) (
  input  logic        FPGA_CLK1_50,
  input  logic        FPGA_CLK2_50,
  input  logic        FPGA_CLK3_50,
  output logic [7:0]  LED,
  input  logic [1:0]  KEY,
  input  logic [3:0]  SW,
  output logic        ADC_CONVST,
  output logic        ADC_SCK,
  output logic        ADC_SDI,
  input  logic        ADC_SDO,
  output logic [15:0] ARDUINO_IO,
  output logic        ARDUINO_RESET_N
);

  import soc_pkg::*;

  logic       clk;
  logic       rst;
  logic       rst_meta;
  logic       start;
  bus_req_t   bus_req;
  bus_rsp_t   bus_rsp;
  logic [7:0] core_led;
  logic       spi_sck;
  logic       spi_mosi;
  logic       spi_cs;
  logic       spi_dc;
  logic       shield_inv;

  // No PLL, board oscillator drives everything
  assign clk = FPGA_CLK1_50;

  // Two-flop reset synchroniser on KEY[0]
  always_ff @(posedge clk) begin
    rst_meta <= ~KEY[0];
    rst      <= rst_meta;
  end

  assign start = ~KEY[1];

  riscv riscv0 (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .bus_out (bus_req),
    .bus_in  (bus_rsp),
    .led     (core_led)
  );

  mem #(
    .ADDR_LO (MEM_LO),
    .ADDR_HI (MEM_HI)
  ) mem0 (
    .clk     (clk),
    .rst     (rst),
    .bus_in  (bus_req),
    .bus_out (bus_rsp)
  );

  shield_v1 #(
    .SPI_DIV (SPI_DIV)
  ) shield0 (
    .clk        (clk),
    .rst        (rst),
    .spi_sck    (spi_sck),
    .spi_mosi   (spi_mosi),
    .spi_cs     (spi_cs),
    .spi_dc     (spi_dc),
    .inv        (shield_inv),
    .adc_convst (ADC_CONVST),
    .adc_sck    (ADC_SCK),
    .adc_sdi    (ADC_SDI)
  );

  // Shield header pins, the rest parked low
  always_comb begin
    ARDUINO_IO     = 16'd0;
    ARDUINO_IO[8]  = spi_dc;
    ARDUINO_IO[10] = spi_cs;
    ARDUINO_IO[11] = spi_mosi;
    ARDUINO_IO[13] = spi_sck;
  end

  assign ARDUINO_RESET_N = 1'b1;

  // SPI pins mirrored on the upper LEDs
  assign LED[7] = spi_mosi;
  assign LED[6] = spi_dc;
  assign LED[5] = spi_cs;
  assign LED[4] = spi_sck;
  assign LED[3:2] = core_led[1:0];
  assign LED[1] = shield_inv;
  assign LED[0] = rst;

endmodule

/* verilog/shield_v1.sv */
module shield_v1 #(
  parameter int SPI_DIV = 4
) (
  input  logic clk,
  input  logic rst,
  output logic spi_sck,
  output logic spi_mosi,
  output logic spi_cs,
  output logic spi_dc,
  output logic inv,
  output logic adc_convst,
  output logic adc_sck,
  output logic adc_sdi
);

  import soc_pkg::*;

  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
  localparam int IDX_W = (DISP_INIT_LEN > 1) ? $clog2(DISP_INIT_LEN) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic [IDX_W-1:0] byte_idx;
  logic [7:0]       shift;
  logic             half_done;
  logic             last_byte;
  logic             load;

  assign half_done = (div_cnt == DIV_W'(SPI_DIV - 1));
  assign last_byte = (byte_idx == IDX_W'(DISP_INIT_LEN - 1));
  assign load = spi_cs && !inv;
  assign spi_mosi = shift[7];

  // ADC is not converting
  assign adc_convst = 1'b0;
  assign adc_sck = 1'b0;
  assign adc_sdi = 1'b0;

  // Framing, clock divider and byte walk
  always_ff @(posedge clk) begin
    if (rst) begin
      spi_cs   <= 1'b1;
      spi_sck  <= 1'b0;
      inv      <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= 3'd0;
      byte_idx <= '0;
    end else if (spi_cs) begin
      if (!inv) begin
        spi_cs  <= 1'b0;
        div_cnt <= '0;
        bit_cnt <= 3'd0;
      end
    end else begin
      div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      if (half_done) begin
        spi_sck <= ~spi_sck;
        // Falling edge closes the bit
        if (spi_sck) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            spi_cs   <= 1'b1;
            byte_idx <= byte_idx + 1'b1;
            if (last_byte) inv <= 1'b1;
          end
        end
      end
    end
  end

  // Shift register, MSB first, next bit set up while sck is low
  always_ff @(posedge clk) begin
    if (load) begin
      shift  <= DISP_INIT[byte_idx].data;
      spi_dc <= DISP_INIT[byte_idx].dc;
    end else if (!spi_cs && half_done && spi_sck) begin
      shift <= {shift[6:0], 1'b0};
    end
  end

endmodule

/* verilog/mem.sv */
module mem #(
  parameter logic [15:0] ADDR_LO = 16'h0000,
  parameter logic [15:0] ADDR_HI = 16'h0FFF
) (
  input  logic              clk,
  input  logic              rst,
  input  soc_pkg::bus_req_t bus_in,
  output soc_pkg::bus_rsp_t bus_out
);

  localparam int DEPTH = (int'(ADDR_HI) - int'(ADDR_LO) + 1) / 2;
  localparam int AW    = $clog2(DEPTH);

  logic [15:0]   ram [DEPTH];
  logic [15:0]   offset;
  logic [AW-1:0] idx;
  logic          hit;

  initial begin
    $readmemh("program.hex", ram);
  end

  // Window decode and byte address to halfword index
  assign offset = bus_in.addr - ADDR_LO;
  assign idx = offset[AW:1];
  // Offset wraps below ADDR_LO, so one compare covers both ends of the window
  assign hit = bus_in.req && (offset <= (ADDR_HI - ADDR_LO));

  // One-cycle ack one clock after req
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_out.ack <= 1'b0;
    end else begin
      bus_out.ack <= hit && !bus_out.ack;
    end
  end

  // Request is still up during its ack cycle, so skip it then
  always_ff @(posedge clk) begin
    if (hit && !bus_out.ack) begin
      if (bus_in.write) begin
        ram[idx] <= bus_in.wdata;
      end else begin
        bus_out.rdata <= ram[idx];
      end
    end
  end

endmodule

/* verilog/riscv.sv */
module riscv (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output soc_pkg::bus_req_t bus_out,
  input  soc_pkg::bus_rsp_t bus_in,
  output logic [7:0]        led
);

  import soc_pkg::*;

  core_state_e state;
  opcode_e     opcode;

  logic [15:0] pc;
  logic [31:0] instr;
  logic [15:0] load_lo;
  logic [31:0] result;

  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic [31:0] alu_out;
  logic [31:0] ea;
  logic        take_branch;
  logic        led_store;
  logic        is_load;

  riscv_regfile regfile0 (
    .clk      (clk),
    .rs1_addr (instr[19:15]),
    .rs2_addr (instr[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (state == ST_WB),
    .rd_addr  (instr[11:7]),
    .rd_data  (result)
  );

  // Decode
  assign opcode = opcode_e'(instr[6:0]);
  assign is_load = (opcode == OP_LOAD);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};

  // Effective address stays valid through the memory states
  assign ea = rs1_data + ((opcode == OP_STORE) ? imm_s : imm_i);
  assign led_store = (opcode == OP_STORE) && (ea[15:0] == LED_ADDR);

  // funct3[0] picks BNE over BEQ
  assign take_branch = instr[12] ? (rs1_data != rs2_data) : (rs1_data == rs2_data);

  always_comb begin
    case (opcode)
      OP_LUI:   alu_out = imm_u;
      OP_OPIMM: alu_out = rs1_data + imm_i;
      OP_OP:    alu_out = instr[30] ? (rs1_data - rs2_data) : (rs1_data + rs2_data);
      OP_JAL:   alu_out = {16'd0, pc + 16'd4};
      default:  alu_out = 32'd0;
    endcase
  end

  // Bus master, low halfword first
  always_comb begin
    bus_out = '0;
    case (state)
      ST_FETCH_LO: begin
        bus_out.req  = 1'b1;
        bus_out.addr = pc;
      end
      ST_FETCH_HI: begin
        bus_out.req  = 1'b1;
        bus_out.addr = pc + 16'd2;
      end
      ST_MEM_LO: begin
        bus_out.req   = 1'b1;
        bus_out.write = !is_load;
        bus_out.addr  = ea[15:0];
        bus_out.wdata = rs2_data[15:0];
      end
      ST_MEM_HI: begin
        bus_out.req   = 1'b1;
        bus_out.write = !is_load;
        bus_out.addr  = ea[15:0] + 16'd2;
        bus_out.wdata = rs2_data[31:16];
      end
      default: begin
      end
    endcase
  end

  // Control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      pc    <= 16'd0;
      led   <= 8'd0;
    end else begin
      case (state)
        ST_IDLE: if (start) state <= ST_FETCH_LO;
        ST_FETCH_LO: if (bus_in.ack) state <= ST_FETCH_HI;
        ST_FETCH_HI: if (bus_in.ack) state <= ST_EXEC;
        ST_EXEC: begin
          pc    <= pc + 16'd4;
          state <= ST_WB;
          case (opcode)
            OP_LUI, OP_OPIMM, OP_OP: begin
            end
            OP_LOAD: state <= ST_MEM_LO;
            OP_STORE: begin
              if (led_store) begin
                led   <= rs2_data[7:0];
                state <= ST_FETCH_LO;
              end else begin
                state <= ST_MEM_LO;
              end
            end
            OP_BRANCH: begin
              state <= ST_FETCH_LO;
              if (take_branch) pc <= pc + imm_b[15:0];
            end
            OP_JAL: begin
              // Jump to self ends the program
              if (imm_j == 32'd0) begin
                pc    <= pc;
                state <= ST_HALT;
              end else begin
                pc <= pc + imm_j[15:0];
              end
            end
            default: state <= ST_HALT;
          endcase
        end
        ST_MEM_LO: if (bus_in.ack) state <= ST_MEM_HI;
        ST_MEM_HI: if (bus_in.ack) state <= is_load ? ST_WB : ST_FETCH_LO;
        ST_WB: state <= ST_FETCH_LO;
        ST_HALT: begin
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Instruction and data capture
  always_ff @(posedge clk) begin
    if ((state == ST_FETCH_LO) && bus_in.ack) instr[15:0] <= bus_in.rdata;
    if ((state == ST_FETCH_HI) && bus_in.ack) instr[31:16] <= bus_in.rdata;
    if ((state == ST_MEM_LO) && bus_in.ack) load_lo <= bus_in.rdata;
    if (state == ST_EXEC) begin
      result <= alu_out;
    end else if ((state == ST_MEM_HI) && bus_in.ack) begin
      result <= {bus_in.rdata, load_lo};
    end
  end

endmodule

/* verilog/riscv_regfile.sv */
module riscv_regfile (
  input  logic        clk,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data
);

  logic [31:0] regs [32];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (we && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational read ports, x0 forced to zero
  always_comb begin
    if (rs1_addr == 5'd0) begin
      rs1_data = 32'd0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr == 5'd0) begin
      rs2_data = 32'd0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

/* verilog/soc_pkg.sv */
package soc_pkg;

  // Request from the core, held until ack
  typedef struct packed {
    logic        req;
    logic        write;
    logic [15:0] addr;
    logic [15:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] rdata;
  } bus_rsp_t;

  // RV32I major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_OPIMM  = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_FETCH_LO,
    ST_FETCH_HI,
    ST_EXEC,
    ST_MEM_LO,
    ST_MEM_HI,
    ST_WB,
    ST_HALT
  } core_state_e;

  // LED register lives inside the core
  localparam logic [15:0] LED_ADDR = 16'hFF00;

  localparam int DISP_INIT_LEN = 8;

  typedef struct packed {
    logic       dc;
    logic [7:0] data;
  } disp_init_byte_t;

  // Display bring-up, dc 0 for command and 1 for parameter
  localparam disp_init_byte_t DISP_INIT [DISP_INIT_LEN] = '{
    '{dc: 1'b0, data: 8'h01},
    '{dc: 1'b0, data: 8'h11},
    '{dc: 1'b0, data: 8'h3A},
    '{dc: 1'b1, data: 8'h05},
    '{dc: 1'b0, data: 8'h36},
    '{dc: 1'b1, data: 8'h00},
    '{dc: 1'b0, data: 8'h29},
    '{dc: 1'b0, data: 8'h2C}
  };

endpackage
